//--- triangle_draw_top.f
src/draw_pkg.sv
src/pace_timer.sv
src/line_drawer.sv
src/edge_sequencer.sv
src/triangle_draw_top.sv
bench/triangle_draw_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the triangle outline engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module triangle_draw_tb \
    -f triangle_draw_top.f --Mdir obj_dir -o triangle_draw_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/triangle_draw_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log && echo "simulation PASSED" && exit 0
echo "simulation ended without a verdict" && exit 1

//--- bench/triangle_draw_tb.sv
////////////////////////////////////////////////////////////////////////////
// triangle outline engine testbench
// random and directed triangles checked against an error-term line model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module triangle_draw_tb import draw_pkg::*; ();

    logic   clk_100m, rst_n, tri_start, busy, pix_we, tri_done;
    coord_t x0, y0, x1, y1, x2, y2, pix_x, pix_y;
    cidx_t  cidx, pix_cidx;
    coord_t exp_x[$], exp_y[$];         // model pixel queue in drawing order
    coord_t ex, ey;
    cidx_t  exp_cidx;
    int     exp_cnt, pix_cnt, last_cyc;
    int     cyc = 0;
    bit     seen_pix, done_seen, in_flight;

    triangle_draw_top triangle_draw_top_i (.*);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    always @(posedge clk_100m) cyc <= cyc + 1;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pixel(input coord_t gx, gy, input cidx_t gc,
                               input coord_t wx, wy, input cidx_t wc);
        string msg;
        if (gx !== wx || gy !== wy || gc !== wc) begin
            msg = $sformatf("Mismatch at %0d ns: pixel (%0d,%0d) colour %0d",
                            $time, gx, gy, gc);
            msg = {msg, $sformatf(", expected (%0d,%0d) colour %0d", wx, wy, wc)};
            abort_run(msg);
        end
    endtask

    task automatic check_count(input int got, input int want);
        if (got != want)
            abort_run($sformatf("Mismatch at %0d ns: %0d pixels in triangle, expected %0d",
                                $time, got, want));
    endtask

    // error-term walk including the endpoint
    task automatic model_line(input int ax, ay, bx, by);
        int x, y, dx, dy, sx, sy, err, e2;
        dx  = (bx > ax) ? bx - ax : ax - bx;
        dy  = (by > ay) ? by - ay : ay - by;
        sx  = (bx < ax) ? -1 : 1;
        sy  = (by < ay) ? -1 : 1;
        x   = ax;
        y   = ay;
        err = dx - dy;
        exp_x.push_back(coord_t'(x));
        exp_y.push_back(coord_t'(y));
        while (x != bx || y != by) begin
            e2 = 2 * err;
            if (e2 > -dy) begin
                err = err - dy;
                x   = x + sx;
            end
            if (e2 < dx) begin
                err = err + dx;
                y   = y + sy;
            end
            exp_x.push_back(coord_t'(x));
            exp_y.push_back(coord_t'(y));
        end
    endtask

    // pixel and done monitor on the falling edge
    always @(negedge clk_100m) begin
        if (rst_n && pix_we) begin
            if (exp_x.size() == 0)
                abort_run("a pixel write strobe arrived while no pixel was expected");
            if (seen_pix && (cyc - last_cyc) < PACE_DIV)
                abort_run($sformatf("Mismatch at %0d ns: pixel strobes %0d cycles apart",
                                    $time, cyc - last_cyc));
            ex = exp_x.pop_front();
            ey = exp_y.pop_front();
            check_pixel(pix_x, pix_y, pix_cidx, ex, ey, exp_cidx);
            seen_pix = 1'b1;
            last_cyc = cyc;
            pix_cnt  = pix_cnt + 1;
        end
        if (rst_n && tri_done) begin
            if (!in_flight)
                abort_run("tri_done pulsed while no triangle was in progress");
            if (busy)
                abort_run($sformatf("Mismatch at %0d ns: busy still high with tri_done", $time));
            check_count(pix_cnt, exp_cnt);
            done_seen = 1'b1;
        end
    end

    task automatic draw_triangle(input int ax, ay, bx, by, cx, cy, col, input bit interfere);
        int budget;
        int t;
        exp_x.delete();
        exp_y.delete();
        model_line(ax, ay, bx, by);
        model_line(bx, by, cx, cy);
        model_line(cx, cy, ax, ay);
        exp_cnt   = exp_x.size();
        exp_cidx  = cidx_t'(col);
        pix_cnt   = 0;
        done_seen = 1'b0;
        in_flight = 1'b1;
        budget    = (exp_cnt + 8) * PACE_DIV * 2;
        @(posedge clk_100m);
        {x0, y0} <= {coord_t'(ax), coord_t'(ay)};
        {x1, y1} <= {coord_t'(bx), coord_t'(by)};
        {x2, y2} <= {coord_t'(cx), coord_t'(cy)};
        cidx      <= cidx_t'(col);
        tri_start <= 1'b1;
        @(posedge clk_100m);
        tri_start <= 1'b0;
        @(negedge clk_100m);
        if (!busy)
            abort_run("busy did not rise in the cycle after tri_start");
        if (interfere) begin
            t = 0;
            while (pix_cnt < 2) begin
                @(posedge clk_100m);
                t = t + 1;
                if (t > budget)
                    abort_run("timed out waiting for the first pixels of a triangle");
            end
            x0        <= coord_t'(CORD_MAX - ax);   // strobe while busy
            y1        <= coord_t'(CORD_MAX - by);
            cidx      <= ~cidx_t'(col);
            tri_start <= 1'b1;
            @(posedge clk_100m);
            tri_start <= 1'b0;
        end
        t = 0;
        while (!done_seen) begin
            @(posedge clk_100m);
            t = t + 1;
            if (t > budget)
                abort_run("timed out waiting for tri_done");
        end
        in_flight = 1'b0;
    endtask

    initial begin
        int v[6];
        void'($urandom(32'he86d_5d09));
        rst_n     = 1'b0;
        tri_start = 1'b0;
        {x0, y0, x1, y1, x2, y2} = '0;
        cidx      = '0;
        repeat (16) @(posedge clk_100m);
        rst_n <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_100m);
            if (busy || pix_we)
                abort_run("busy or pix_we went high before the first tri_start");
        end
        draw_triangle(0, 0, CORD_MAX, 0, 0, CORD_MAX, 5, 1'b0);     // axes and long diagonal
        draw_triangle(0, CORD_MAX, CORD_MAX, 0, 0, 0, 9, 1'b0);     // reverse winding
        draw_triangle(100, 100, 100, 100, 100, 100, 3, 1'b0);       // single point
        draw_triangle(10, 10, 50, 50, 30, 30, 7, 1'b0);             // collinear diagonal
        draw_triangle(5, 0, 7, 40, 9, 80, 1, 1'b0);                 // collinear steep
        draw_triangle(160, 160, 170, 20, 20, 150, 12, 1'b0);        // negative directions
        draw_triangle(160, 160, 300, 170, 150, 310, 14, 1'b1);
        for (int i = 0; i < 40; i++) begin
            foreach (v[k])
                v[k] = $urandom_range(CORD_MAX);
            draw_triangle(v[0], v[1], v[2], v[3], v[4], v[5], $urandom_range(15),
                          (i % 10) == 3);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- src/triangle_draw_top.sv
////////////////////////////////////////////////////////////////////////////
// triangle outline engine top level
// sequencer, pacing timer and line drawer emitting pixel write strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module triangle_draw_top import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   tri_start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    input  coord_t x2,
    input  coord_t y2,
    input  cidx_t  cidx,
    output logic   busy,
    output logic   pix_we,
    output coord_t pix_x,
    output coord_t pix_y,
    output cidx_t  pix_cidx,
    output logic   tri_done
);

    logic   line_start;
    logic   line_done;
    logic   drawing_en;
    logic   step;               // pixel pacing tick
    coord_t lx0, ly0, lx1, ly1; // current edge endpoints

    edge_sequencer edge_sequencer_i (
        .clk_100m,
        .rst_n,
        .tri_start,
        .x0,
        .y0,
        .x1,
        .y1,
        .x2,
        .y2,
        .cidx,
        .line_done,
        .line_start,
        .lx0,
        .ly0,
        .lx1,
        .ly1,
        .pix_cidx,
        .drawing_en,
        .busy,
        .tri_done
    );

    pace_timer pace_timer_i (
        .clk_100m,
        .rst_n,
        .drawing_en,
        .step
    );

    line_drawer line_drawer_i (
        .clk_100m,
        .rst_n,
        .line_start,
        .lx0,
        .ly0,
        .lx1,
        .ly1,
        .step,
        .pix_we,
        .pix_x,
        .pix_y,
        .line_done
    );

endmodule

//--- src/edge_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// triangle edge sequencer
// latches a triangle and runs the line drawer over edges 0-1, 1-2, 2-0
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_sequencer import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   tri_start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    input  coord_t x2,
    input  coord_t y2,
    input  cidx_t  cidx,
    input  logic   line_done,
    output logic   line_start,
    output coord_t lx0,
    output coord_t ly0,
    output coord_t lx1,
    output coord_t ly1,
    output cidx_t  pix_cidx,
    output logic   drawing_en,
    output logic   busy,
    output logic   tri_done
);

    seq_state_t state;
    coord_t     vx0, vy0, vx1, vy1, vx2, vy2;   // latched vertices
    logic [1:0] edge_cnt;
    logic [1:0] edge_nxt;
    logic       last_edge;
    logic       accept;
    logic       load_edge;
    coord_t     sel_x0, sel_y0, sel_x1, sel_y1;

    assign accept     = (state == IDLE) && tri_start;   // ignored while busy
    assign last_edge  = (edge_cnt == 2'd2);
    assign edge_nxt   = (state == LOAD) ? 2'd0 : edge_cnt + 2'd1;
    assign load_edge  = (state == LOAD) ||
                        ((state == WAIT_EDGE) && line_done && !last_edge);
    assign line_start = (state == EDGE);
    assign drawing_en = busy;

    // endpoint select for the edge about to start
    always_comb begin
        case (edge_nxt)
            2'd0: begin
                sel_x0 = vx0;
                sel_y0 = vy0;
                sel_x1 = vx1;
                sel_y1 = vy1;
            end
            2'd1: begin
                sel_x0 = vx1;
                sel_y0 = vy1;
                sel_x1 = vx2;
                sel_y1 = vy2;
            end
            default: begin      // closing edge
                sel_x0 = vx2;
                sel_y0 = vy2;
                sel_x1 = vx0;
                sel_y1 = vy0;
            end
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state    <= IDLE;
            edge_cnt <= 2'd0;
            busy     <= 1'b0;
            tri_done <= 1'b0;
        end else begin
            tri_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (tri_start) begin
                        busy  <= 1'b1;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    edge_cnt <= edge_nxt;
                    state    <= EDGE;
                end
                EDGE: state <= WAIT_EDGE;
                WAIT_EDGE: begin
                    if (line_done) begin
                        if (last_edge) begin
                            tri_done <= 1'b1;   // busy drops in the same cycle
                            busy     <= 1'b0;
                            state    <= IDLE;
                        end else begin
                            edge_cnt <= edge_nxt;
                            state    <= EDGE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // triangle and endpoint registers
    always_ff @(posedge clk_100m) begin
        if (accept) begin
            vx0      <= x0;
            vy0      <= y0;
            vx1      <= x1;
            vy1      <= y1;
            vx2      <= x2;
            vy2      <= y2;
            pix_cidx <= cidx;   // held for the whole triangle
        end
        if (load_edge) begin
            lx0 <= sel_x0;
            ly0 <= sel_y0;
            lx1 <= sel_x1;
            ly1 <= sel_y1;
        end
    end

endmodule

//--- src/line_drawer.sv
////////////////////////////////////////////////////////////////////////////
// error-term line rasteriser for all octants
// walks from (lx0,ly0) to (lx1,ly1), one pixel per step tick
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module line_drawer import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   line_start,
    input  coord_t lx0,
    input  coord_t ly0,
    input  coord_t lx1,
    input  coord_t ly1,
    input  logic   step,
    output logic   pix_we,
    output coord_t pix_x,
    output coord_t pix_y,
    output logic   line_done
);

    // deltas need one bit more than a coordinate, the doubled error two more
    logic signed [16:0] dx_raw, dy_raw;
    logic signed [16:0] dx_abs, dy_abs;
    logic signed [16:0] dx, dy;         // absolute deltas of the active line
    logic signed [18:0] err;            // running error term
    logic signed [18:0] e2;             // doubled error
    logic signed [18:0] err_nxt;

    coord_t x, y;                       // current point
    coord_t x_end, y_end;
    logic   x_inc, y_inc;               // step direction, 1 means increment
    logic   move_x, move_y;
    logic   at_end;
    logic   active;
    logic   last_px;                    // end point went out this cycle

    assign dx_raw = 17'(lx1) - 17'(lx0);
    assign dy_raw = 17'(ly1) - 17'(ly0);
    assign dx_abs = dx_raw[16] ? -dx_raw : dx_raw;
    assign dy_abs = dy_raw[16] ? -dy_raw : dy_raw;

    assign e2     = err <<< 1;
    assign move_x = (e2 > -19'(dy));
    assign move_y = (e2 < 19'(dx));
    assign at_end = (x == x_end) && (y == y_end);

    always_comb begin
        err_nxt = err;
        if (move_x) begin
            err_nxt = err_nxt - 19'(dy);
        end
        if (move_y) begin
            err_nxt = err_nxt + 19'(dx);
        end
    end

    // control
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            active    <= 1'b0;
            pix_we    <= 1'b0;
            last_px   <= 1'b0;
            line_done <= 1'b0;
        end else begin
            pix_we    <= 1'b0;
            last_px   <= 1'b0;
            line_done <= last_px;       // one cycle after the last pixel
            if (line_start) begin
                active <= 1'b1;
            end else if (active && step) begin
                pix_we <= 1'b1;
                if (at_end) begin
                    active  <= 1'b0;
                    last_px <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk_100m) begin
        if (line_start) begin
            x     <= lx0;
            y     <= ly0;
            x_end <= lx1;
            y_end <= ly1;
            dx    <= dx_abs;
            dy    <= dy_abs;
            x_inc <= !dx_raw[16];
            y_inc <= !dy_raw[16];
            err   <= 19'(dx_abs) - 19'(dy_abs);    // dx minus dy
        end else if (active && step) begin
            pix_x <= x;
            pix_y <= y;
            if (!at_end) begin
                err <= err_nxt;
                if (move_x) begin
                    x <= x_inc ? x + 16'sd1 : x - 16'sd1;
                end
                if (move_y) begin
                    y <= y_inc ? y + 16'sd1 : y - 16'sd1;
                end
            end
        end
    end

endmodule

//--- src/pace_timer.sv
////////////////////////////////////////////////////////////////////////////
// pacing timer
// emits one step tick every PACE_DIV cycles while drawing is enabled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pace_timer import draw_pkg::*; (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic drawing_en,
    output logic step
);

    logic [PACE_W-1:0] cnt;     // position within the pacing period
    logic              wrap;

    assign wrap = (cnt == PACE_W'(PACE_DIV - 1));

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            cnt  <= '0;
            step <= 1'b0;
        end else if (!drawing_en) begin
            cnt  <= '0;         // restart for the next triangle
            step <= 1'b0;
        end else if (wrap) begin
            cnt  <= '0;
            step <= 1'b1;       // one tick per period
        end else begin
            cnt  <= cnt + 1'b1;
            step <= 1'b0;
        end
    end

endmodule

//--- src/draw_pkg.sv
////////////////////////////////////////////////////////////////////////////
// triangle outline engine shared definitions
// coordinate and colour types, sequencer states, drawing constants
////////////////////////////////////////////////////////////////////////////

package draw_pkg;

    // screen coordinate, signed so edges may run in any direction
    typedef logic signed [15:0] coord_t;

    // palette colour index
    typedef logic [3:0] cidx_t;

    // largest legal coordinate on either axis
    localparam int CORD_MAX = 319;

    // clk_100m cycles per drawing step
    localparam int PACE_DIV = 4;

    // pacing counter width
    localparam int PACE_W = (PACE_DIV > 1) ? $clog2(PACE_DIV) : 1;

    // edge sequencer states
    typedef enum logic [1:0] {
        IDLE,       // waiting for a triangle
        LOAD,       // pick endpoints of first edge
        EDGE,       // kick the line drawer
        WAIT_EDGE   // line in progress
    } seq_state_t;

endpackage
